// File: flist.f
+incdir+design
+incdir+test
design/riscv_lsu_pkg.sv
design/riscv_lsu.sv
design/data_ram_lane.sv
design/riscv_data_mem.sv
test/tb_riscv_data_mem.sv

// File: test/lsu_ref_model.svh
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

// Lanes a store may touch, none for misaligned or load-only sizes
function automatic logic [3:0] store_lane_mask(
    input logic [`RV_XLEN-1:0]      addr,
    input riscv_lsu_pkg::mem_size_t size
);
    logic [1:0] off;

    off = addr[1:0];
    if (size == riscv_lsu_pkg::SIZE_B) begin
        return 4'b0001 << off;
    end
    if (size == riscv_lsu_pkg::SIZE_H && !off[0]) begin
        return 4'b0011 << off;
    end
    if (size == riscv_lsu_pkg::SIZE_W && off == 2'b00) begin
        return 4'b1111;
    end
    return 4'b0000;
endfunction

// Store data starts at the addressed byte and runs upward
function automatic logic [7:0] store_lane_byte(
    input logic [`RV_XLEN-1:0] wdata,
    input logic [`RV_XLEN-1:0] addr,
    input int                  lane
);
    logic [`RV_XLEN-1:0] shifted;

    shifted = wdata >> (8 * (lane - int'(addr[1:0])));
    return shifted[7:0];
endfunction

function automatic logic [`RV_XLEN-1:0] extract_load(
    input logic [`RV_XLEN-1:0]      word,
    input logic [`RV_XLEN-1:0]      addr,
    input riscv_lsu_pkg::mem_size_t size
);
    logic [`RV_XLEN-1:0] shifted;
    logic [1:0]          off;

    off     = addr[1:0];
    shifted = word >> (8 * off);   // Addressed byte moved to bit 0
    case (size)
        riscv_lsu_pkg::SIZE_B:  return {{24{shifted[7]}}, shifted[7:0]};
        riscv_lsu_pkg::SIZE_BU: return {24'h0, shifted[7:0]};
        riscv_lsu_pkg::SIZE_H:  return off[0] ? '0 : {{16{shifted[15]}}, shifted[15:0]};
        riscv_lsu_pkg::SIZE_HU: return off[0] ? '0 : {16'h0, shifted[15:0]};
        riscv_lsu_pkg::SIZE_W:  return (off == 2'b00) ? word : '0;
        default:                return '0;
    endcase
endfunction

// 13/17/5 xorshift, never reaches zero from a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;

    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

// File: test/tb_riscv_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_lsu_settings.svh"

module tb_riscv_data_mem;

    localparam int STALL_TIMEOUT = 16;
    localparam int RANDOM_OPS    = 300;
    localparam int WINDOW_WORDS  = 64;

    logic                    clk_in;
    logic                    rst_in;
    riscv_lsu_pkg::lsu_req_t req;
    logic                    new_request_in;
    logic                    cache_miss_out;
    logic [`RV_XLEN-1:0]     cpu_data_out;

    logic [7:0]  shadow [4 << `RV_MEM_WORD_BITS];   // Byte-addressed copy of the RAM
    logic [31:0] rng_state;
    int          checks;
    int          errors;

    `include "lsu_ref_model.svh"

    riscv_data_mem riscv_data_mem_inst (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .req            (req),
        .new_request_in (new_request_in),
        .cache_miss_out (cache_miss_out),
        .cpu_data_out   (cpu_data_out)
    );

    always #4 clk_in = ~clk_in;

    // *********************************************************
    // Stall timing
    // *********************************************************

    // Reset cycles included
    a_no_read: assert property (@(posedge clk_in) !req.re |-> !cache_miss_out)
        else begin
            errors++;
            $display("FAILED t=%0t cache_miss_out expected 0 got %0b",
                     $time, $sampled(cache_miss_out));
        end

    a_stall_t0: assert property (@(posedge clk_in) disable iff (rst_in)
        new_request_in && req.re |-> cache_miss_out)
        else begin
            errors++;
            $display("FAILED t=%0t cache_miss_out (T0) expected 1 got %0b",
                     $time, $sampled(cache_miss_out));
        end

    a_stall_t1: assert property (@(posedge clk_in) disable iff (rst_in)
        $past(new_request_in && req.re) && !new_request_in |-> cache_miss_out)
        else begin
            errors++;
            $display("FAILED t=%0t cache_miss_out (T1) expected 1 got %0b",
                     $time, $sampled(cache_miss_out));
        end

    a_stall_t2: assert property (@(posedge clk_in) disable iff (rst_in)
        $past(new_request_in && req.re, 2) && !$past(new_request_in) && !new_request_in
        |-> !cache_miss_out)
        else begin
            errors++;
            $display("FAILED t=%0t cache_miss_out (T2) expected 0 got %0b",
                     $time, $sampled(cache_miss_out));
        end

    // *********************************************************
    // Helpers
    // *********************************************************

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] mirror_word(input logic [31:0] addr);
        logic [`RV_MEM_WORD_BITS+1:0] base;

        base = {addr[`RV_MEM_WORD_BITS+1:2], 2'b00};   // Upper bits alias
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    task automatic mirror_store(input logic [31:0] addr, input logic [31:0] value,
                                input riscv_lsu_pkg::mem_size_t sz);
        logic [3:0]                   mask;
        logic [`RV_MEM_WORD_BITS+1:0] base;

        mask = store_lane_mask(addr, sz);
        base = {addr[`RV_MEM_WORD_BITS+1:2], 2'b00};
        for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) begin
                shadow[base + lane] = store_lane_byte(value, addr, lane);
            end
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        assert (got === expected)
            else begin
                errors++;
                $display("FAILED t=%0t %s expected %08h got %08h", $time, name, expected, got);
            end
    endtask

    task automatic wait_stall_clear();
        int n;

        n = 0;
        @(negedge clk_in);
        while (cache_miss_out && n < STALL_TIMEOUT) begin
            @(negedge clk_in);
            n++;
        end
        if (cache_miss_out) begin
            errors++;
            $display("Timeout: cache_miss_out still high after %0d cycles", STALL_TIMEOUT);
        end
    endtask

    // *********************************************************
    // Requests
    // *********************************************************

    task automatic write_request(input logic [31:0] addr, input logic [31:0] value,
                                 input riscv_lsu_pkg::mem_size_t sz);
        @(posedge clk_in);
        req            <= '{addr, value, sz, 1'b1, 1'b0};
        new_request_in <= 1'b1;
        @(posedge clk_in);               // Write commits at this edge
        new_request_in <= 1'b0;
        mirror_store(addr, value, sz);
    endtask

    task automatic read_request(input logic [31:0] addr, input riscv_lsu_pkg::mem_size_t sz);
        @(posedge clk_in);
        req            <= '{addr, 32'h0, sz, 1'b0, 1'b1};
        new_request_in <= 1'b1;
        @(posedge clk_in);
        new_request_in <= 1'b0;
        wait_stall_clear();              // Returns in T2
        check_word("cpu_data_out", cpu_data_out, extract_load(mirror_word(addr), addr, sz));
    endtask

    // Second read lands in the T1 of the first
    task automatic restart_reads(input logic [31:0] first_addr, input logic [31:0] second_addr);
        @(posedge clk_in);
        req            <= '{first_addr, 32'h0, riscv_lsu_pkg::SIZE_W, 1'b0, 1'b1};
        new_request_in <= 1'b1;
        @(posedge clk_in);
        req            <= '{second_addr, 32'h0, riscv_lsu_pkg::SIZE_W, 1'b0, 1'b1};
        new_request_in <= 1'b1;
        @(posedge clk_in);
        new_request_in <= 1'b0;
        @(negedge clk_in);
        check_word("cache_miss_out", 32'(cache_miss_out), 32'h1);
        wait_stall_clear();
        check_word("cpu_data_out", cpu_data_out, mirror_word(second_addr));
    endtask

    // *********************************************************
    // Main sequence
    // *********************************************************

    initial begin
        logic [31:0]               r;
        logic [31:0]               d;
        logic [31:0]               addr;
        riscv_lsu_pkg::mem_size_t  sizes [5];

        sizes[0]       = riscv_lsu_pkg::SIZE_B;
        sizes[1]       = riscv_lsu_pkg::SIZE_H;
        sizes[2]       = riscv_lsu_pkg::SIZE_W;
        sizes[3]       = riscv_lsu_pkg::SIZE_BU;
        sizes[4]       = riscv_lsu_pkg::SIZE_HU;
        clk_in         = 1'b0;
        rst_in         = 1'b1;
        req            = '0;
        new_request_in = 1'b0;
        rng_state      = 32'h96c5;
        checks         = 0;
        errors         = 0;

        repeat (2) begin
            @(negedge clk_in);
            check_word("cache_miss_out", 32'(cache_miss_out), 32'h0);
            check_word("cpu_data_out", cpu_data_out, 32'h0);
        end
        @(posedge clk_in);               // Third edge in reset
        rst_in <= 1'b0;
        @(negedge clk_in);
        check_word("cache_miss_out", 32'(cache_miss_out), 32'h0);
        check_word("cpu_data_out", cpu_data_out, 32'h0);

        // Known contents for the whole window
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            write_request(w << 2, fill_pattern(w << 2), riscv_lsu_pkg::SIZE_W);
        end

        draw_random(d);
        write_request(32'h10, d, riscv_lsu_pkg::SIZE_W);
        read_request(32'h10, riscv_lsu_pkg::SIZE_W);

        // Sub-word stores, one lane at a time
        write_request(32'h40, 32'h8a7f_e516, riscv_lsu_pkg::SIZE_W);
        for (int off = 0; off < 4; off++) begin
            draw_random(d);
            write_request(32'h40 + off, d, riscv_lsu_pkg::SIZE_B);
            read_request(32'h40, riscv_lsu_pkg::SIZE_W);
        end
        draw_random(d);
        write_request(32'h40, d, riscv_lsu_pkg::SIZE_H);
        read_request(32'h40, riscv_lsu_pkg::SIZE_W);
        draw_random(d);
        write_request(32'h42, d, riscv_lsu_pkg::SIZE_H);
        read_request(32'h40, riscv_lsu_pkg::SIZE_W);

        write_request(32'h44, 32'h81f2_7e93, riscv_lsu_pkg::SIZE_W);   // Mixed sign bits
        for (int base = 32'h40; base <= 32'h44; base += 4) begin
            for (int off = 0; off < 4; off++) begin
                read_request(base + off, riscv_lsu_pkg::SIZE_B);
                read_request(base + off, riscv_lsu_pkg::SIZE_BU);
            end
            for (int off = 0; off < 4; off += 2) begin
                read_request(base + off, riscv_lsu_pkg::SIZE_H);
                read_request(base + off, riscv_lsu_pkg::SIZE_HU);
            end
            read_request(base, riscv_lsu_pkg::SIZE_W);
        end

        // Misaligned stores must leave the word alone, misaligned loads give zero
        draw_random(d);
        write_request(32'h49, d, riscv_lsu_pkg::SIZE_H);
        write_request(32'h4b, ~d, riscv_lsu_pkg::SIZE_H);
        for (int off = 1; off < 4; off++) begin
            draw_random(d);
            write_request(32'h48 + off, d, riscv_lsu_pkg::SIZE_W);
        end
        read_request(32'h48, riscv_lsu_pkg::SIZE_W);
        check_word("cpu_data_out", cpu_data_out, fill_pattern(32'h48));   // Fill value intact
        for (int off = 1; off < 4; off += 2) begin
            read_request(32'h48 + off, riscv_lsu_pkg::SIZE_H);
            read_request(32'h48 + off, riscv_lsu_pkg::SIZE_HU);
        end
        for (int off = 1; off < 4; off++) begin
            read_request(32'h48 + off, riscv_lsu_pkg::SIZE_W);
        end

        restart_reads(32'h20, 32'h24);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            draw_random(r);
            draw_random(d);
            addr = {r[31:12], 4'h0, r[9:4], r[1:0]};   // 64-word window, random alias bits
            if (r[2]) begin
                write_request(addr, d, sizes[d % 3]);
            end else begin
                read_request(addr, sizes[d % 5]);
            end
        end

        repeat (2) @(posedge clk_in);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/riscv_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_lsu_settings.svh"

module riscv_data_mem (
    input  wire                            clk_in,
    input  wire                            rst_in,

    input  wire riscv_lsu_pkg::lsu_req_t   req,
    input  wire                            new_request_in,
    output logic                           cache_miss_out,
    output logic [`RV_XLEN-1:0]            cpu_data_out
);

    localparam int NUM_LANES = `RV_XLEN / 8;

    riscv_lsu_pkg::mem_bus_t   mem_bus;
    logic [`RV_XLEN-1:0]       mem_rdata;   // Lane bytes, lane 0 lowest

    // *********************************************************
    // Load/store unit
    // *********************************************************

    riscv_lsu riscv_lsu_inst (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .req            (req),
        .new_request_in (new_request_in),
        .cache_miss_out (cache_miss_out),
        .cpu_data_out   (cpu_data_out),
        .mem_bus        (mem_bus),
        .mem_rdata      (mem_rdata)
    );

    // *********************************************************
    // Byte lanes
    // *********************************************************

    generate
        for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
            data_ram_lane #(
                .DEPTH (`RV_MEM_DEPTH)
            ) data_ram_lane_inst (
                .clk_in     (clk_in),
                .rst_in     (rst_in),
                .word_index (mem_bus.word_index),          // Shared by all lanes
                .wdata      (mem_bus.wdata[8*lane +: 8]),
                .byte_en    (mem_bus.byte_en[lane]),
                .rdata      (mem_rdata[8*lane +: 8])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/data_ram_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_lsu_settings.svh"

module data_ram_lane #(
    parameter int DEPTH = `RV_MEM_DEPTH
) (
    input  wire                          clk_in,
    input  wire                          rst_in,

    input  wire [`RV_MEM_WORD_BITS-1:0]  word_index,
    input  wire [7:0]                    wdata,
    input  wire                          byte_en,
    output logic [7:0]                   rdata
);

    logic [7:0]                   mem [DEPTH];
    logic [`RV_MEM_WORD_BITS-1:0] addr_q;

    // Write commits at the end of the request cycle
    always_ff @(posedge clk_in) begin
        if (byte_en) begin
            mem[word_index] <= wdata;
        end
    end

    // *********************************************************
    // Two-stage read: address register, then data register
    // *********************************************************

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            addr_q <= '0;
            rdata  <= 8'h00;
        end else begin
            addr_q <= word_index;     // End of T0
            rdata  <= mem[addr_q];    // End of T1
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_lsu_settings.svh"

module riscv_lsu (
    input  wire                            clk_in,
    input  wire                            rst_in,

    input  wire riscv_lsu_pkg::lsu_req_t   req,
    input  wire                            new_request_in,
    output logic                           cache_miss_out,
    output logic [`RV_XLEN-1:0]            cpu_data_out,

    output riscv_lsu_pkg::mem_bus_t        mem_bus,
    input  wire [`RV_XLEN-1:0]             mem_rdata
);

    riscv_lsu_pkg::lsu_state_t state;
    logic                      valid;     // Read data already delivered

    logic [1:0]  byte_off;
    logic        half_aligned;
    logic        word_aligned;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign byte_off     = req.addr[1:0];
    assign half_aligned = ~byte_off[0];
    assign word_aligned = (byte_off == 2'b00);

    // *********************************************************
    // Stall generation
    // *********************************************************

    // High in T0 and T1 of a read, low from T2 on
    assign cache_miss_out = new_request_in ? req.re :
                            (req.re && (state != riscv_lsu_pkg::FINISH) && !valid);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= riscv_lsu_pkg::IDLE;
            valid <= 1'b0;
        end else if (new_request_in) begin
            state <= riscv_lsu_pkg::WAIT1;   // Count restarts from this T0
            valid <= 1'b0;
        end else begin
            case (state)
                riscv_lsu_pkg::WAIT1: begin
                    state <= riscv_lsu_pkg::FINISH;
                end
                riscv_lsu_pkg::FINISH: begin
                    state <= riscv_lsu_pkg::IDLE;
                    valid <= 1'b1;
                end
                default: begin
                    state <= riscv_lsu_pkg::IDLE;
                end
            endcase
        end
    end

    // *********************************************************
    // Store steering
    // *********************************************************

    always_comb begin
        mem_bus.word_index = req.addr[`RV_MEM_WORD_BITS+1:2];
        mem_bus.wdata      = '0;
        mem_bus.byte_en    = '0;

        if (req.we) begin
            case (req.size)
                riscv_lsu_pkg::SIZE_B: begin
                    // Byte copied to every lane, enable picks one
                    mem_bus.wdata = {4{req.wdata[7:0]}};
                    case (byte_off)
                        2'd0: mem_bus.byte_en = 4'b0001;
                        2'd1: mem_bus.byte_en = 4'b0010;
                        2'd2: mem_bus.byte_en = 4'b0100;
                        2'd3: mem_bus.byte_en = 4'b1000;
                        default: mem_bus.byte_en = 4'b0000;
                    endcase
                end
                riscv_lsu_pkg::SIZE_H: begin
                    mem_bus.wdata = {2{req.wdata[15:0]}};
                    if (half_aligned) begin
                        mem_bus.byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
                    end
                end
                riscv_lsu_pkg::SIZE_W: begin
                    mem_bus.wdata = req.wdata;
                    if (word_aligned) begin
                        mem_bus.byte_en = 4'b1111;
                    end
                end
                default: begin
                    mem_bus.wdata   = '0;   // Unsigned codes are load-only
                    mem_bus.byte_en = '0;
                end
            endcase
        end
    end

    // *********************************************************
    // Load extraction
    // *********************************************************

    always_comb begin
        case (byte_off)
            2'd0: ld_byte = mem_rdata[7:0];
            2'd1: ld_byte = mem_rdata[15:8];
            2'd2: ld_byte = mem_rdata[23:16];
            2'd3: ld_byte = mem_rdata[31:24];
            default: ld_byte = 8'h00;
        endcase

        // Only meaningful when half_aligned
        ld_half = byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];
    end

    always_comb begin
        cpu_data_out = '0;

        if (req.re) begin
            case (req.size)
                riscv_lsu_pkg::SIZE_B: begin
                    cpu_data_out = {{(`RV_XLEN-8){ld_byte[7]}}, ld_byte};
                end
                riscv_lsu_pkg::SIZE_BU: begin
                    cpu_data_out = {{(`RV_XLEN-8){1'b0}}, ld_byte};
                end
                riscv_lsu_pkg::SIZE_H: begin
                    if (half_aligned) begin
                        cpu_data_out = {{(`RV_XLEN-16){ld_half[15]}}, ld_half};
                    end
                end
                riscv_lsu_pkg::SIZE_HU: begin
                    if (half_aligned) begin
                        cpu_data_out = {{(`RV_XLEN-16){1'b0}}, ld_half};
                    end
                end
                riscv_lsu_pkg::SIZE_W: begin
                    if (word_aligned) begin
                        cpu_data_out = mem_rdata;
                    end
                end
                default: begin
                    cpu_data_out = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_lsu_pkg.sv
`default_nettype none

`include "riscv_lsu_settings.svh"

package riscv_lsu_pkg;

    // funct3 width codes of LB/LH/LW/LBU/LHU and SB/SH/SW
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } mem_size_t;

    // Read-wait FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT1,
        FINISH
    } lsu_state_t;

    // One CPU access, held until the next new_request_in pulse
    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        mem_size_t           size;
        logic                we;
        logic                re;
    } lsu_req_t;

    // LSU to lane RAMs
    typedef struct packed {
        logic [`RV_MEM_WORD_BITS-1:0] word_index;
        logic [`RV_XLEN-1:0]          wdata;
        logic [`RV_XLEN/8-1:0]        byte_en;   // One bit per lane
    } mem_bus_t;

endpackage

`default_nettype wire

// File: design/riscv_lsu_settings.svh
`ifndef RISCV_LSU_SETTINGS_SVH
`define RISCV_LSU_SETTINGS_SVH

// Data path and address width
`define RV_XLEN 32

// Word index comes from addr[11:2], upper address bits alias
`define RV_MEM_WORD_BITS 10

// 1024 words, 4 KiB
`define RV_MEM_DEPTH (1 << `RV_MEM_WORD_BITS)

`endif
